//--- sim.f
+incdir+hw
+incdir+test
hw/busPkg.sv
hw/regPkg.sv
hw/zoneDecode.sv
hw/ioRegs.sv
hw/dtackGen.sv
hw/neoC1.sv
test/neoC1Tb.sv

//--- build.sh
#!/bin/sh
# Builds the testbench with Verilator, runs it and looks for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f sim.f --top-module neoC1Tb -o neoC1Sim
status=$?
if [ $status -ne 0 ]; then
	echo "Verilator build failed with status $status"
	exit 1
fi

out=$(./obj_dir/neoC1Sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if echo "$out" | grep -qx "No errors"; then
	exit 0
fi
exit 1

//--- test/c1Ref.svh
`ifndef C1_REF_SVH
`define C1_REF_SVH

`include "c1Cfg.svh"

// Expected active-low selects with the MSB first as listed in selNames
function automatic logic [26:0] activeLowSelects(
	input logic [7:0] a,
	input logic uds,
	input logic lds,
	input logic rwIn,
	input logic as
);
	logic u, l, r, w, word, anyLane;
	logic rom, wram, port, io, pal, card, srom, sram, lsp;
	logic crdO, crdW;
	u = !as && !uds;
	l = !as && !lds;
	r = rwIn;
	w = !rwIn;
	word = u && l;
	anyLane = u || l;
	rom = (a[7:4] == 4'h0);
	wram = (a[7:4] == 4'h1);
	port = (a[7:4] == 4'h2);
	io = (a[7:4] == 4'h3);
	pal = (a[7:6] == 2'b01);	// 4xxxxx..7xxxxx
	card = (a[7:6] == 2'b10);	// 8xxxxx..Bxxxxx
	srom = (a[7:4] == 4'hC);
	sram = (a[7:4] == 4'hD);
	lsp = io && (a[3:1] == 3'd6);
	crdO = card && word && r;
	crdW = card && word && w;
	return ~{rom && l && r, rom && u && r,
		port && l && r, port && u && r, port && l && w, port && u && w, port && anyLane,
		wram && l && r, wram && u && r, wram && l && w, wram && u && w,
		srom && l && r, srom && u && r,
		sram && l && r, sram && u && r, sram && l && w, sram && u && w,
		lsp && word && r, lsp && word && w,
		crdO, crdW, crdO || crdW,
		io && l && r && (a[3:1] == 3'd0), io && l && r && (a[3:1] == 3'd1),
		io && l && w && (a[3:1] == 3'd4), io && l && w && (a[3:1] == 3'd5),
		pal && anyLane};
endfunction

// Expected upper lane read packed as {dataOe, dataOut}
function automatic logic [8:0] upperLaneRead(
	input logic [7:0] a,
	input logic uds,
	input logic rwIn,
	input logic as,
	input logic [9:0] p1,
	input logic [9:0] p2,
	input logic cd1,
	input logic cd2,
	input logic wp,
	input logic [7:0] reply
);
	logic [7:0] d;
	logic oe;
	oe = !as && !uds && rwIn && (a[7:4] == 4'h3);
	d = 8'h00;
	case (a[3:1])
		3'd0: d = p1[7:0];
		3'd1: d = reply;
		3'd2, 3'd3: d = p2[7:0];
		3'd4: d = {wp, (`C1_CONSOLE_MODE != 0), cd2, cd1, p2[9:8], p1[9:8]};
		default: oe = 1'b0;
	endcase
	return oe ? {1'b1, d} : 9'h000;
endfunction

function automatic logic isIcomWrite(
	input logic [7:0] a,
	input logic uds,
	input logic rwIn,
	input logic as
);
	return !as && !uds && !rwIn && (a[7:4] == 4'h3) && (a[3:1] == 3'd1);
endfunction

// Clocks from the edge that samples AS low to DTACK low
function automatic int dtackDelay(input logic [7:0] a);
	case (a[7:4])
		4'h0: return 1 + `C1_WAIT_ROM;
		4'h1: return 1 + `C1_WAIT_WRAM;
		4'h3: return 1 + `C1_WAIT_IO;
		default: return 1 + `C1_WAIT_OTHER;
	endcase
endfunction

`endif

//--- test/neoC1Tb.sv
`include "c1Cfg.svh"

module neoC1Tb;
	localparam int NUM_RANDOM = 60;
	localparam int NUM_READ = 16;
	localparam int NUM_WRITE = 8;	// ICOM write plus a write elsewhere
	localparam int NUM_HOLD = 12;
	localparam int NUM_BUS = NUM_RANDOM + NUM_READ + 2 * NUM_WRITE + 9 + NUM_HOLD;
	localparam int CLK_PER_BUS = 20;	// Worst case with a held wait line
	localparam int WATCHDOG = 200 + NUM_BUS * CLK_PER_BUS * 50;

	logic clk68k, rst;
	logic [23:16] addr;
	logic nUds, nLds, rw, nAs;
	logic [9:0] p1In, p2In;
	logic nCd1, nCd2, nWp;
	logic nRomWait, nPWait0, nPWait1, nPDtack;
	logic [7:0] dataIn, soundReply;
	logic nRomOeL, nRomOeU, nPortOeL, nPortOeU, nPortWeL, nPortWeU, nPortAdrs;
	logic nWrL, nWrU, nWwL, nWwU, nSromOeL, nSromOeU;
	logic nSramOeL, nSramOeU, nSramWeL, nSramWeU, nLspOe, nLspWe;
	logic nCrdO, nCrdW, nCrdC, nDipRd0, nDipRd1, nBitW0, nBitW1, nPal;
	logic nDtack, dataOe;
	logic [7:0] dataOut, soundCmd;
	logic [26:0] actSel;
	logic [7:0] expSound;	// Model of the sound command latch
	logic cmpOn;
	int errors, checks;
	string selNames [27] = '{"nRomOeL", "nRomOeU", "nPortOeL", "nPortOeU", "nPortWeL",
		"nPortWeU", "nPortAdrs", "nWrL", "nWrU", "nWwL", "nWwU", "nSromOeL", "nSromOeU",
		"nSramOeL", "nSramOeU", "nSramWeL", "nSramWeU", "nLspOe", "nLspWe", "nCrdO",
		"nCrdW", "nCrdC", "nDipRd0", "nDipRd1", "nBitW0", "nBitW1", "nPal"};
	logic [7:0] regionAddr [9] = '{8'h05, 8'h15, 8'h25, 8'h35, 8'h45, 8'h85, 8'hC5, 8'hD5, 8'hE5};
	logic [7:0] readAddr [4] = '{8'h30, 8'h34, 8'h38, 8'h32};
	logic [7:0] otherAddr [4] = '{8'h30, 8'h36, 8'h22, 8'h12};

	`include "c1Ref.svh"

	neoC1 DUT (.*);

	assign actSel = {nRomOeL, nRomOeU, nPortOeL, nPortOeU, nPortWeL, nPortWeU, nPortAdrs,
		nWrL, nWrU, nWwL, nWwU, nSromOeL, nSromOeU, nSramOeL, nSramOeU, nSramWeL, nSramWeU,
		nLspOe, nLspWe, nCrdO, nCrdW, nCrdC, nDipRd0, nDipRd1, nBitW0, nBitW1, nPal};

	initial begin
		clk68k = 1'b0;
		forever #5 clk68k = ~clk68k;
	end

	initial begin
		#(WATCHDOG);
		$display("Watchdog expired after %0d time units with bus cycles still running", WATCHDOG);
		$display("Errors found");
		$finish;
	end

	task automatic releaseHolds;
		nRomWait = 1'b1;
		nPWait0 = 1'b1;
		nPWait1 = 1'b1;
		nPDtack = 1'b0;	// Port acknowledges at once
	endtask

	// One CPU cycle with holdKind 1 for ROM wait, 2 and 3 for port waits and 4 for port DTACK
	task automatic busCycle(
		input logic [7:0] a,
		input logic uds,
		input logic lds,
		input logic rwIn,
		input logic [7:0] wdata,
		input int holdKind,
		input int holdLen,
		input bit exact
	);
		int cycles;
		int expD;
		bit acked;
		logic held;
		expD = dtackDelay(a);
		cycles = 0;
		acked = 1'b0;
		@(posedge clk68k);
		#1;
		addr = a;
		nUds = uds;
		nLds = lds;
		rw = rwIn;
		dataIn = wdata;
		nAs = 1'b0;
		p1In = 10'($urandom());
		p2In = 10'($urandom());
		{nCd1, nCd2, nWp} = 3'($urandom());
		soundReply = 8'($urandom());
		case (holdKind)
			1: nRomWait = 1'b0;
			2: nPWait0 = 1'b0;
			3: nPWait1 = 1'b0;
			4: nPDtack = 1'b1;
			default: ;
		endcase
		while (!acked && cycles < 40) begin
			@(posedge clk68k);
			#1;
			held = !nRomWait || !nPWait0 || !nPWait1 || nPDtack;	// What the last edge saw
			if (cycles >= holdLen)
				releaseHolds();
			@(negedge clk68k);
			cycles++;
			if (held && !nDtack) begin
				errors++;
				$display("nDtack fell while a wait input was still held, address %h", a);
			end
			acked = !nDtack;
		end
		checks++;
		if (!acked) begin
			errors++;
			$display("nDtack did not fall within 40 cycles, address %h", a);
		end else if (exact && cycles - 1 != expD) begin
			errors++;
			$display("ERROR nDtack delay: expected %h, got %h", expD, cycles - 1);
		end else if (cycles - 1 < expD) begin
			errors++;
			$display("ERROR nDtack delay: expected at least %h, got %h", expD, cycles - 1);
		end
		@(posedge clk68k);
		#1;
		nAs = 1'b1;
		nUds = 1'b1;
		nLds = 1'b1;
		rw = 1'b1;
		releaseHolds();
		@(negedge clk68k);
		if (acked && nDtack !== 1'b0) begin
			errors++;
			$display("ERROR nDtack: expected %h, got %h", 1'b0, nDtack);
		end
		@(negedge clk68k);
		if (nDtack !== 1'b1) begin	// One edge after AS is seen high
			errors++;
			$display("ERROR nDtack: expected %h, got %h", 1'b1, nDtack);
		end
	endtask

	always @(negedge clk68k) begin : compare
		logic [26:0] expS;
		logic [8:0] expR;
		int i;
		if (cmpOn) begin
			expS = activeLowSelects(addr, nUds, nLds, rw, nAs);
			expR = upperLaneRead(addr, nUds, rw, nAs, p1In, p2In, nCd1, nCd2, nWp, soundReply);
			checks++;
			for (i = 0; i < 27; i++) begin
				if (actSel[26 - i] !== expS[26 - i]) begin
					errors++;
					$display("ERROR %s: expected %h, got %h", selNames[i], expS[26 - i],
						actSel[26 - i]);
				end
			end
			if (dataOe !== expR[8]) begin
				errors++;
				$display("ERROR dataOe: expected %h, got %h", expR[8], dataOe);
			end
			if (dataOut !== expR[7:0]) begin
				errors++;
				$display("ERROR dataOut: expected %h, got %h", expR[7:0], dataOut);
			end
			if (soundCmd !== expSound) begin
				errors++;
				$display("ERROR soundCmd: expected %h, got %h", expSound, soundCmd);
			end
			if (isIcomWrite(addr, nUds, rw, nAs))
				expSound = dataIn;	// Latched on the coming edge
		end
	end

	initial begin
		int i;
		int kind;
		logic [7:0] wbyte;
		void'($urandom(32'h2547237a));
		errors = 0;
		checks = 0;
		cmpOn = 1'b0;
		expSound = 8'h00;
		rst = 1'b1;
		addr = 8'h00;
		{nUds, nLds, rw, nAs} = 4'b1111;
		p1In = 10'h000;
		p2In = 10'h000;
		{nCd1, nCd2, nWp} = 3'b111;
		dataIn = 8'h00;
		soundReply = 8'h00;
		releaseHolds();
		repeat (2) @(posedge clk68k);
		#1;
		rst = 1'b0;
		@(negedge clk68k);
		checks++;
		if (nDtack !== 1'b1) begin
			errors++;
			$display("ERROR nDtack: expected %h, got %h", 1'b1, nDtack);
		end
		if (dataOe !== 1'b0) begin
			errors++;
			$display("ERROR dataOe: expected %h, got %h", 1'b0, dataOe);
		end
		if (soundCmd !== 8'h00) begin
			errors++;
			$display("ERROR soundCmd: expected %h, got %h", 8'h00, soundCmd);
		end
		cmpOn = 1'b1;

		for (i = 0; i < 9; i++)
			busCycle(regionAddr[i], 1'b0, 1'b0, 1'($urandom()), 8'($urandom()), 0, 0, 1'b1);
		for (i = 0; i < NUM_READ; i++)
			busCycle(readAddr[i % 4], 1'b0, 1'($urandom()), 1'b1, 8'h00, 0, 0, 1'b1);
		for (i = 0; i < NUM_WRITE; i++) begin
			wbyte = 8'($urandom());
			busCycle(8'h32, 1'b0, 1'($urandom()), 1'b0, wbyte, 0, 0, 1'b1);
			checks++;
			if (soundCmd !== wbyte) begin
				errors++;
				$display("ERROR soundCmd: expected %h, got %h", wbyte, soundCmd);
			end
			busCycle(otherAddr[i % 4], 1'b0, 1'b0, 1'b0, ~wbyte, 0, 0, 1'b1);
			if (soundCmd !== wbyte) begin	// No other write may touch it
				errors++;
				$display("ERROR soundCmd: expected %h, got %h", wbyte, soundCmd);
			end
		end
		for (i = 0; i < NUM_RANDOM; i++)
			busCycle(8'($urandom()), 1'($urandom()), 1'($urandom()), 1'($urandom()),
				8'($urandom()), 0, 0, 1'b1);
		for (i = 0; i < NUM_HOLD; i++) begin
			kind = 1 + i % 4;
			busCycle(kind == 1 ? 8'h07 : 8'h2A, 1'b0, 1'b0, 1'b1, 8'h00, kind,
				int'($urandom_range(10, 1)), 1'b0);
		end

		cmpOn = 1'b0;
		$display("Summary: %0d checks, %0d mismatches", checks, errors);
		if (errors == 0)
			$display("No errors");
		else
			$display("Errors found");
		$finish;
	end

endmodule

//--- hw/neoC1.sv
`include "c1Cfg.svh"

module neoC1 (
	input  logic clk68k,
	input  logic rst,
	input  logic [23:16] addr,
	input  logic nUds, nLds,
	input  logic rw, nAs,
	input  logic [9:0] p1In,
	input  logic [9:0] p2In,
	input  logic nCd1, nCd2, nWp,
	input  logic nRomWait,
	input  logic nPWait0, nPWait1,
	input  logic nPDtack,
	input  logic [`C1_DATA_W-1:0] dataIn,
	input  logic [`C1_DATA_W-1:0] soundReply,
	output logic nRomOeL, nRomOeU,
	output logic nPortOeL, nPortOeU,
	output logic nPortWeL, nPortWeU,
	output logic nPortAdrs,
	output logic nWrL, nWrU,
	output logic nWwL, nWwU,
	output logic nSromOeL, nSromOeU,
	output logic nSramOeL, nSramOeU,
	output logic nSramWeL, nSramWeU,
	output logic nLspOe, nLspWe,
	output logic nCrdO, nCrdW, nCrdC,
	output logic nDipRd0, nDipRd1,
	output logic nBitW0, nBitW1,
	output logic nPal,
	output logic nDtack,
	output logic [`C1_DATA_W-1:0] dataOut,
	output logic dataOe,
	output logic [`C1_DATA_W-1:0] soundCmd
);
	import busPkg::*;
	import regPkg::*;

	busRegion_t region;
	busAccess_t access;
	ioReg_t ioSel;
	logic [`C1_DATA_W-1:0] regData;	// Register mux before the lane drive

	zoneDecode decode (.*);

	ioRegs execute (
		.clk68k(clk68k),
		.rst(rst),
		.access(access),
		.ioSel(ioSel),
		.nAs(nAs),
		.dataIn(dataIn),
		.p1In(p1In),
		.p2In(p2In),
		.nCd1(nCd1),
		.nCd2(nCd2),
		.nWp(nWp),
		.soundReply(soundReply),
		.dataOut(regData),
		.dataOe(dataOe),
		.soundCmd(soundCmd)
	);

	dtackGen result (.*);

	// Upper lane stays quiet unless a register is read
	assign dataOut = dataOe ? regData : '0;

endmodule

//--- hw/dtackGen.sv
`include "c1Cfg.svh"

module dtackGen (
	input  logic clk68k,
	input  logic rst,
	input  logic nAs,
	input  busPkg::busRegion_t region,
	input  logic nRomWait,
	input  logic nPWait0,
	input  logic nPWait1,
	input  logic nPDtack,
	output logic nDtack
);
	import busPkg::*;

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_COUNT,	// Fixed wait states running
		ST_EXTWAIT,	// Port cycle waiting on its own DTACK
		ST_ACK
	} dtackState_t;

	dtackState_t state, stateNext;
	logic [`C1_WAIT_CNT_W-1:0] waitCnt;
	logic [`C1_WAIT_CNT_W-1:0] waitLoad;
	busRegion_t cycRegion;	// Region of the running cycle
	logic extHold;

	always_comb begin
		case (region)
			REGION_ROM:  waitLoad = `C1_WAIT_CNT_W'(`C1_WAIT_ROM);
			REGION_WRAM: waitLoad = `C1_WAIT_CNT_W'(`C1_WAIT_WRAM);
			REGION_IO:   waitLoad = `C1_WAIT_CNT_W'(`C1_WAIT_IO);
			default:     waitLoad = `C1_WAIT_CNT_W'(`C1_WAIT_OTHER);
		endcase
	end

	// External wait lines freeze the count
	// Either port wait line stretches a port cycle
	assign extHold = ((cycRegion == REGION_ROM) && !nRomWait) ||
		((cycRegion == REGION_PORT) && !(nPWait0 && nPWait1));

	always_comb begin
		stateNext = state;
		case (state)
			ST_IDLE: if (!nAs) stateNext = ST_COUNT;
			ST_COUNT: begin
				if (nAs)
					stateNext = ST_IDLE;	// Cycle aborted
				else if (!extHold && waitCnt == '0)
					stateNext = (cycRegion == REGION_PORT && nPDtack) ? ST_EXTWAIT : ST_ACK;
			end
			ST_EXTWAIT: begin
				if (nAs)
					stateNext = ST_IDLE;
				else if (!nPDtack)
					stateNext = ST_ACK;
			end
			default: if (nAs) stateNext = ST_IDLE;
		endcase
	end

	always_ff @(posedge clk68k) begin
		if (rst)
			state <= ST_IDLE;
		else
			state <= stateNext;
	end

	// Loaded on the edge that first sees AS low
	always_ff @(posedge clk68k) begin
		if (state == ST_IDLE) begin
			waitCnt <= waitLoad;
			cycRegion <= region;
		end else if (state == ST_COUNT && !extHold && waitCnt != '0) begin
			waitCnt <= waitCnt - 1'b1;
		end
	end

	assign nDtack = (state != ST_ACK);

endmodule

//--- hw/ioRegs.sv
`include "c1Cfg.svh"

module ioRegs (
	input  logic clk68k,
	input  logic rst,
	input  busPkg::busAccess_t access,
	input  regPkg::ioReg_t ioSel,
	input  logic nAs,
	input  logic [`C1_DATA_W-1:0] dataIn,
	input  logic [9:0] p1In,
	input  logic [9:0] p2In,
	input  logic nCd1,
	input  logic nCd2,
	input  logic nWp,
	input  logic [`C1_DATA_W-1:0] soundReply,
	output logic [`C1_DATA_W-1:0] dataOut,
	output logic dataOe,
	output logic [`C1_DATA_W-1:0] soundCmd
);
	import busPkg::*;
	import regPkg::*;

	logic [`C1_DATA_W-1:0] statusB;
	logic icomWrite;

	// Card lines, board variant and the start/select pairs
	assign statusB = {
		nWp,
		1'(`C1_CONSOLE_MODE),
		nCd2,
		nCd1,
		p2In[9:8],
		p1In[9:8]
	};

	// Read mux, lane drive is qualified by dataOe
	always_comb begin
		case (ioSel)
			IO_CTRL1:   dataOut = p1In[7:0];
			IO_CTRL2:   dataOut = p2In[7:0];
			IO_ICOM:    dataOut = soundReply;	// Reply from the Z80 side
			IO_STATUSB: dataOut = statusB;
			default:    dataOut = '0;
		endcase
	end

	assign dataOe = (access == ACCESS_READ) && (ioSel != IO_NONE);

	// Sound command write, held for the Z80 to pick up
	assign icomWrite = (access == ACCESS_WRITE) && (ioSel == IO_ICOM) && !nAs;

	always_ff @(posedge clk68k) begin
		if (rst) begin
			soundCmd <= '0;
		end else if (icomWrite) begin
			soundCmd <= dataIn;
		end
	end

endmodule

//--- hw/zoneDecode.sv
module zoneDecode (
	input  logic [23:16] addr,
	input  logic nUds,
	input  logic nLds,
	input  logic rw,
	input  logic nAs,
	output busPkg::busRegion_t region,
	output busPkg::busAccess_t access,
	output regPkg::ioReg_t ioSel,
	output logic nRomOeL, nRomOeU,
	output logic nPortOeL, nPortOeU,
	output logic nPortWeL, nPortWeU,
	output logic nPortAdrs,
	output logic nWrL, nWrU,
	output logic nWwL, nWwU,
	output logic nSromOeL, nSromOeU,
	output logic nSramOeL, nSramOeU,
	output logic nSramWeL, nSramWeU,
	output logic nLspOe, nLspWe,
	output logic nCrdO, nCrdW, nCrdC,
	output logic nDipRd0, nDipRd1,
	output logic nBitW0, nBitW1,
	output logic nPal
);
	import busPkg::*;
	import regPkg::*;

	logic upper;	// Even lane strobed inside a cycle
	logic lower;	// Odd lane strobed inside a cycle
	logic anyLane;
	logic word;
	logic rd;
	logic wr;
	logic inRom, inWram, inPort, inIo;
	logic inPal, inCard, inSrom, inSram;
	logic inLsp;	// Line sprite chip, 3Cxxxx and 3Dxxxx
	logic [2:0] ioAddr;

	always_comb begin
		case (addr[23:20])
			4'h0: region = REGION_ROM;
			4'h1: region = REGION_WRAM;
			4'h2: region = REGION_PORT;
			4'h3: region = REGION_IO;
			4'h4, 4'h5, 4'h6, 4'h7: region = REGION_PAL;
			4'h8, 4'h9, 4'hA, 4'hB: region = REGION_CARD;
			4'hC: region = REGION_SROM;
			4'hD: region = REGION_SRAM;
			default: region = REGION_NONE;
		endcase
	end

	assign inRom  = (region == REGION_ROM);
	assign inWram = (region == REGION_WRAM);
	assign inPort = (region == REGION_PORT);
	assign inIo   = (region == REGION_IO);
	assign inPal  = (region == REGION_PAL);
	assign inCard = (region == REGION_CARD);
	assign inSrom = (region == REGION_SROM);
	assign inSram = (region == REGION_SRAM);

	// Strobes only count while AS is low
	assign upper   = ~nAs & ~nUds;
	assign lower   = ~nAs & ~nLds;
	assign anyLane = upper | lower;
	assign word    = upper & lower;
	assign rd      = rw;
	assign wr      = ~rw;

	assign access = accessOf(nAs, nUds, nLds, rw);

	// Sub-block of the I/O area, 128 kB each
	assign ioAddr = addr[19:17];
	assign inLsp  = inIo & (ioAddr == 3'b110);

	// C1 registers sit on the even lane only
	assign ioSel = (inIo && upper) ? ioRegOf(ioAddr) : IO_NONE;

	assign nRomOeL  = ~(inRom & lower & rd);
	assign nRomOeU  = ~(inRom & upper & rd);
	assign nWrL     = ~(inWram & lower & rd);
	assign nWrU     = ~(inWram & upper & rd);
	assign nWwL     = ~(inWram & lower & wr);
	assign nWwU     = ~(inWram & upper & wr);
	assign nPortOeL = ~(inPort & lower & rd);
	assign nPortOeU = ~(inPort & upper & rd);
	assign nPortWeL = ~(inPort & lower & wr);
	assign nPortWeU = ~(inPort & upper & wr);
	assign nPortAdrs = ~(inPort & anyLane);	// Port address latch, any direction
	assign nSromOeL = ~(inSrom & lower & rd);
	assign nSromOeU = ~(inSrom & upper & rd);
	assign nSramOeL = ~(inSram & lower & rd);
	assign nSramOeU = ~(inSram & upper & rd);
	assign nSramWeL = ~(inSram & lower & wr);
	assign nSramWeU = ~(inSram & upper & wr);

	// Odd lane of the I/O area, decoded only
	assign nDipRd0 = ~(inIo & lower & rd & (ioAddr == 3'b000));
	assign nDipRd1 = ~(inIo & lower & rd & (ioAddr == 3'b001));
	assign nBitW0  = ~(inIo & lower & wr & (ioAddr == 3'b100));
	assign nBitW1  = ~(inIo & lower & wr & (ioAddr == 3'b101));

	// Sprite chip and card are 16 bit devices
	assign nLspOe = ~(inLsp & word & rd);
	assign nLspWe = ~(inLsp & word & wr);
	assign nCrdO  = ~(inCard & word & rd);
	assign nCrdW  = ~(inCard & word & wr);
	assign nCrdC  = nCrdO & nCrdW;	// Card chip select

	assign nPal = ~(inPal & anyLane);

endmodule

//--- hw/regPkg.sv
package regPkg;

	// Registers of the I/O block on the even (upper) lane
	typedef enum logic [2:0] {
		IO_NONE    = 3'd0,
		IO_CTRL1   = 3'd1,	// 30xxxx player 1
		IO_ICOM    = 3'd2,	// 32xxxx sound command and reply
		IO_CTRL2   = 3'd3,	// 34xxxx player 2
		IO_STATUSB = 3'd4	// 38xxxx card and start/select bits
	} ioReg_t;

	// Register from address bits 19..17 inside the I/O block
	// 36xxxx mirrors player 2, 3Axxxx up is not a C1 register
	function automatic ioReg_t ioRegOf(input logic [2:0] sel);
		ioReg_t r;
		case (sel)
			3'b000: r = IO_CTRL1;
			3'b001: r = IO_ICOM;
			3'b010,
			3'b011: r = IO_CTRL2;
			3'b100: r = IO_STATUSB;
			default: r = IO_NONE;
		endcase
		return r;
	endfunction

endpackage

//--- hw/busPkg.sv
package busPkg;

	// Address regions, one per 1 MB block of the 68000 map
	typedef enum logic [3:0] {
		REGION_ROM  = 4'd0,	// 0xxxxx
		REGION_WRAM = 4'd1,	// 1xxxxx
		REGION_PORT = 4'd2,	// 2xxxxx cartridge port
		REGION_IO   = 4'd3,	// 3xxxxx
		REGION_PAL  = 4'd4,	// 4xxxxx to 7xxxxx
		REGION_CARD = 4'd5,	// 8xxxxx to Bxxxxx
		REGION_SROM = 4'd6,	// Cxxxxx
		REGION_SRAM = 4'd7,	// Dxxxxx
		REGION_NONE = 4'd15	// Exxxxx, Fxxxxx
	} busRegion_t;

	// Kind of bus access in progress
	typedef enum logic [1:0] {
		ACCESS_IDLE  = 2'd0,
		ACCESS_READ  = 2'd1,
		ACCESS_WRITE = 2'd2
	} busAccess_t;

	// Access kind from the raw 68000 strobes
	// Idle while AS is high or no lane is selected
	function automatic busAccess_t accessOf(
		input logic nAs,
		input logic nUds,
		input logic nLds,
		input logic rw
	);
		if (nAs || (nUds && nLds))
			return ACCESS_IDLE;
		return rw ? ACCESS_READ : ACCESS_WRITE;
	endfunction

endpackage

//--- hw/c1Cfg.svh
`ifndef C1_CFG_SVH
`define C1_CFG_SVH

// Board variant, read back through bit 6 of the status byte
// 1 selects the arcade board, 0 the home console
`define C1_CONSOLE_MODE 1

// Fixed wait states per region, in clk68k cycles (0 to 7)
// They are added to the single clock that DTACK always costs

// Program ROM
`define C1_WAIT_ROM 1

// Work RAM runs at full speed
`define C1_WAIT_WRAM 0

// I/O block, controller and sound registers
`define C1_WAIT_IO 1

// Port, palette, card, system ROM and RAM
`define C1_WAIT_OTHER 0

// Width of the counter that holds a wait count
`define C1_WAIT_CNT_W 3

// Upper data lane, D15..D8 on the CPU side
`define C1_DATA_W 8

`endif
